/* src/gemm_pkg.sv */
// ----------------------------------------------------------
// shared types, opcodes and APB register map for the GEMM
// issue front end; referenced by scoped names only
// ----------------------------------------------------------
package gemm_pkg;

    // basic vector types
    typedef logic [3:0]  mreg_idx_t;    // matrix register index
    typedef logic [31:0] instr_t;       // raw instruction word
    typedef logic [6:0]  opcode_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [7:0]  fifo_count_t;  // queue fill level

    // matrix opcodes
    localparam opcode_t OPC_GEMM    = 7'h2B;
    localparam opcode_t OPC_STORE_M = 7'h27;

    // APB register offsets
    localparam apb_addr_t REG_CTRL   = 8'h00;  // bit0 freeze, bit1 flush pulse
    localparam apb_addr_t REG_INSTR  = 8'h04;  // write only
    localparam apb_addr_t REG_STATUS = 8'h08;  // count, full, empty
    localparam apb_addr_t REG_OP     = 8'h0C;  // read pops the queue

    // one decoded GEMM; declared msb first so rs1 ends up in the low bits
    typedef struct packed {
        logic      new_weights;
        mreg_idx_t rd;
        mreg_idx_t rs3;
        mreg_idx_t rs2;
        mreg_idx_t rs1;          // weights register
    } gemm_op_t;

    // APB request from the master
    typedef struct packed {
        apb_addr_t   paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB response back to the master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register block to functional unit
    typedef struct packed {
        logic   valid;   // one cycle per instruction
        instr_t word;
        logic   flush;   // one cycle, also empties the queue
    } issue_req_t;

    // functional unit back to register block
    typedef struct packed {
        logic done;
        logic reject;
    } issue_rsp_t;

    // instruction write sequencing in the register block
    typedef enum logic [1:0] {
        IDLE,
        ISSUE_WAIT,
        RESP
    } regs_state_t;

endpackage

/* src/gemm_apb_regs.sv */
// ----------------------------------------------------------
// APB slave for the GEMM front end; forwards instruction
// writes to the unit, holds freeze and pops the op queue
// ----------------------------------------------------------
`timescale 1ns/1ps

module gemm_apb_regs (
    input  logic                  CLK,
    input  logic                  nRST,
    input  gemm_pkg::apb_req_t    apb_req,
    output gemm_pkg::apb_rsp_t    apb_rsp,
    output gemm_pkg::issue_req_t  issue_req,
    input  gemm_pkg::issue_rsp_t  issue_rsp,
    input  gemm_pkg::gemm_op_t    head_op,
    input  gemm_pkg::fifo_count_t count,
    input  logic                  full,
    input  logic                  empty,
    output logic                  pop,
    output logic                  freeze
);

    localparam int OP_PAD = 32 - $bits(gemm_pkg::gemm_op_t);

    gemm_pkg::regs_state_t state, next_state;

    logic access;
    logic idle_access;
    logic sel_ctrl, sel_instr, sel_status, sel_op;
    logic bad_access;
    logic instr_write;
    logic ctrl_write;

    assign access      = apb_req.psel && apb_req.penable;
    assign idle_access = access && (state == gemm_pkg::IDLE);

    assign sel_ctrl   = (apb_req.paddr == gemm_pkg::REG_CTRL);
    assign sel_instr  = (apb_req.paddr == gemm_pkg::REG_INSTR);
    assign sel_status = (apb_req.paddr == gemm_pkg::REG_STATUS);
    assign sel_op     = (apb_req.paddr == gemm_pkg::REG_OP);

    // unknown offset, write to a read-only reg, or read of REG_INSTR
    assign bad_access = !(sel_ctrl || sel_instr || sel_status || sel_op)
                      || (apb_req.pwrite && (sel_status || sel_op))
                      || (!apb_req.pwrite && sel_instr);

    assign instr_write = idle_access && sel_instr && apb_req.pwrite;
    assign ctrl_write  = idle_access && sel_ctrl && apb_req.pwrite;

    // issue strobe on the first access cycle only
    assign issue_req.valid = instr_write;
    assign issue_req.word  = apb_req.pwdata;
    assign issue_req.flush = ctrl_write && apb_req.pwdata[1];

    assign pop = idle_access && sel_op && !apb_req.pwrite && !empty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            freeze <= 1'b0;
        end else if (ctrl_write) begin
            freeze <= apb_req.pwdata[0];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= gemm_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            gemm_pkg::IDLE: begin
                if (instr_write) next_state = gemm_pkg::ISSUE_WAIT;
            end
            gemm_pkg::ISSUE_WAIT: begin
                if (issue_rsp.done) next_state = gemm_pkg::RESP;
            end
            gemm_pkg::RESP: begin
                // let the master leave the access phase first
                if (!access) next_state = gemm_pkg::IDLE;
            end
            default: next_state = gemm_pkg::IDLE;
        endcase
    end

    // response and read data
    always_comb begin
        apb_rsp = '0;
        case (state)
            gemm_pkg::IDLE: begin
                if (access && !instr_write) begin  // single-cycle accesses
                    apb_rsp.pready = 1'b1;
                    if (bad_access) begin
                        apb_rsp.pslverr = 1'b1;
                    end else if (!apb_req.pwrite) begin
                        if (sel_ctrl) begin
                            apb_rsp.prdata = {31'b0, freeze};
                        end else if (sel_status) begin
                            apb_rsp.prdata = {22'b0, empty, full, count};
                        end else if (sel_op) begin
                            if (empty) begin
                                apb_rsp.pslverr = 1'b1;  // nothing to pop
                            end else begin
                                apb_rsp.prdata = {{OP_PAD{1'b0}}, head_op};
                            end
                        end
                    end
                end
            end
            gemm_pkg::ISSUE_WAIT: begin
                apb_rsp.pready  = issue_rsp.done;
                apb_rsp.pslverr = issue_rsp.done && issue_rsp.reject;
            end
            default: apb_rsp = '0;
        endcase
    end

    // unit answers only while the FSM waits for it
    a_done_in_wait: assert property (@(posedge CLK) disable iff (!nRST)
        issue_rsp.done == (state == gemm_pkg::ISSUE_WAIT))
        else $error("unit response outside ISSUE_WAIT or missing in it");

endmodule

/* src/fu_gemm.sv */
// ----------------------------------------------------------
// GEMM functional unit; decodes matrix instructions, applies
// accept/reject and tracks whether the weights must reload
// ----------------------------------------------------------
`timescale 1ns/1ps

module fu_gemm (
    input  logic                 CLK,
    input  logic                 nRST,
    input  gemm_pkg::issue_req_t issue_req,
    input  logic                 freeze,
    input  logic                 fifo_full,
    output gemm_pkg::issue_rsp_t issue_rsp,
    output logic                 push,
    output gemm_pkg::gemm_op_t   op
);

    gemm_pkg::opcode_t   opcode;
    gemm_pkg::mreg_idx_t rs1, rs2, rs3, rd;
    gemm_pkg::mreg_idx_t prev_rs1;   // weights reg of last accepted GEMM

    logic is_gemm, is_store;
    logic reject;
    logic accept_gemm, accept_store;
    logic new_weights;
    logic prev_valid;                // prev_rs1 holds a real GEMM
    logic weights_dirty;             // store hit prev_rs1 since then

    // field slicing
    assign opcode = issue_req.word[6:0];
    assign rs1    = issue_req.word[10:7];
    assign rs2    = issue_req.word[14:11];
    assign rs3    = issue_req.word[18:15];
    assign rd     = issue_req.word[22:19];

    assign is_gemm  = (opcode == gemm_pkg::OPC_GEMM);
    assign is_store = (opcode == gemm_pkg::OPC_STORE_M);

    assign reject = freeze
                  || !(is_gemm || is_store)
                  || (is_gemm && fifo_full);   // queue has no room

    assign accept_gemm  = issue_req.valid && is_gemm && !reject;
    assign accept_store = issue_req.valid && is_store && !reject;

    // reload when nothing is loaded, the weights reg changed, or it was overwritten
    assign new_weights = !prev_valid || (rs1 != prev_rs1) || weights_dirty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_rsp <= '0;
            push      <= 1'b0;
        end else begin
            issue_rsp.done   <= issue_req.valid;
            issue_rsp.reject <= issue_req.valid && reject;
            push             <= accept_gemm;
        end
    end

    // decoded op, only meaningful while push is high
    always_ff @(posedge CLK) begin
        if (accept_gemm) begin
            op.rs1         <= rs1;
            op.rs2         <= rs2;
            op.rs3         <= rs3;
            op.rd          <= rd;
            op.new_weights <= new_weights;
        end
    end

    // weights tracking
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            prev_rs1      <= '0;
            prev_valid    <= 1'b0;
            weights_dirty <= 1'b0;
        end else if (issue_req.flush) begin
            prev_rs1      <= '0;
            prev_valid    <= 1'b0;
            weights_dirty <= 1'b0;
        end else if (accept_gemm) begin
            prev_rs1      <= rs1;
            prev_valid    <= 1'b1;
            weights_dirty <= 1'b0;       // array now holds rs1 again
        end else if (accept_store && prev_valid && (rd == prev_rs1)) begin
            weights_dirty <= 1'b1;
        end
    end

    // valid is a single-cycle strobe per instruction
    a_single_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        issue_req.valid |=> !issue_req.valid)
        else $error("issue valid held for more than one cycle");

endmodule

/* src/gemm_op_fifo.sv */
// ----------------------------------------------------------
// circular queue of decoded GEMM ops between the unit and
// the APB read port; FIFO_DEPTH must be a power of two >= 2
// ----------------------------------------------------------
`timescale 1ns/1ps

module gemm_op_fifo #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  flush,
    input  logic                  push,
    input  gemm_pkg::gemm_op_t    op_in,
    input  logic                  pop,
    output gemm_pkg::gemm_op_t    head_op,
    output gemm_pkg::fifo_count_t count,
    output logic                  full,
    output logic                  empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    gemm_pkg::gemm_op_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == gemm_pkg::fifo_count_t'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head_op = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= op_in;
        end
    end

    // pointers wrap naturally at a power-of-two depth
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
        end
    end

    // upstream reject and pslverr paths must keep these from happening
    a_no_push_full: assert property (@(posedge CLK) disable iff (!nRST)
        push |-> !full)
        else $error("push while queue full");

    a_no_pop_empty: assert property (@(posedge CLK) disable iff (!nRST)
        pop |-> !empty)
        else $error("pop while queue empty");

endmodule

/* src/gemm_issue_top.sv */
// ----------------------------------------------------------
// top of the GEMM issue front end: APB register block, the
// functional unit and the op queue; the bus is the only port
// ----------------------------------------------------------
`timescale 1ns/1ps

module gemm_issue_top #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic               CLK,
    input  logic               nRST,
    input  gemm_pkg::apb_req_t apb_req,
    output gemm_pkg::apb_rsp_t apb_rsp
);

    gemm_pkg::issue_req_t  issue_req;
    gemm_pkg::issue_rsp_t  issue_rsp;
    gemm_pkg::gemm_op_t    push_op;
    gemm_pkg::gemm_op_t    head_op;
    gemm_pkg::fifo_count_t count;

    logic push, pop;
    logic full, empty;
    logic freeze;

    gemm_apb_regs i_gemm_apb_regs (
        .CLK       (CLK),
        .nRST      (nRST),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .issue_req (issue_req),
        .issue_rsp (issue_rsp),
        .head_op   (head_op),
        .count     (count),
        .full      (full),
        .empty     (empty),
        .pop       (pop),
        .freeze    (freeze)
    );

    fu_gemm i_fu_gemm (
        .CLK       (CLK),
        .nRST      (nRST),
        .issue_req (issue_req),
        .freeze    (freeze),
        .fifo_full (full),
        .issue_rsp (issue_rsp),
        .push      (push),
        .op        (push_op)
    );

    gemm_op_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_gemm_op_fifo (
        .CLK     (CLK),
        .nRST    (nRST),
        .flush   (issue_req.flush),   // same pulse clears unit tracking
        .push    (push),
        .op_in   (push_op),
        .pop     (pop),
        .head_op (head_op),
        .count   (count),
        .full    (full),
        .empty   (empty)
    );

endmodule

/* verif/gemm_issue_tb.sv */
// ----------------------------------------------------------
// directed testbench for the GEMM issue front end; drives the
// APB port and checks decode, weights tracking and rejects
// ----------------------------------------------------------
`timescale 1ns/1ps

module gemm_issue_tb;

    localparam int CLK_PERIOD = 100;
    localparam int SAMPLE_DLY = 25;   // after the falling edge, outputs settled
    localparam int DEPTH      = 4;
    localparam int TIMEOUT    = 20;   // cycles per APB access

    logic               CLK = 1'b0;
    logic               nRST;
    gemm_pkg::apb_req_t apb_req;
    gemm_pkg::apb_rsp_t apb_rsp;

    integer             seed = 37;
    gemm_pkg::gemm_op_t want_q[$];    // ops expected in the queue, oldest first

    gemm_issue_top #(
        .FIFO_DEPTH (DEPTH)
    ) i_gemm_issue_top (
        .CLK     (CLK),
        .nRST    (nRST),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check_op(input gemm_pkg::gemm_op_t got, input gemm_pkg::gemm_op_t want,
                            input string what);
        if (got !== want) begin
            stop_run($sformatf("Fail at %0t ns: %s, got %h expected %h", $time, what, got, want));
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            stop_run($sformatf("Fail at %0t ns: %s, got %h expected %h", $time, what, got, want));
        end
    endtask

    task automatic check_err(input logic got, input logic want, input string what);
        if (got !== want) begin
            stop_run($sformatf("Fail at %0t ns: %s, pslverr %b expected %b",
                               $time, what, got, want));
        end
    endtask

    task automatic check_waits(input int got, input int want, input string what);
        if (got != want) begin
            stop_run($sformatf("Fail at %0t ns: %s, %0d wait states expected %0d",
                               $time, what, got, want));
        end
    endtask

    // one APB transfer, setup then access until pready
    task automatic apb_access(input logic write, input gemm_pkg::apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge CLK);
        apb_req.penable = 1'b1;
        #(SAMPLE_DLY);
        while (!apb_rsp.pready) begin
            if (cycles >= TIMEOUT) begin
                stop_run($sformatf("APB access to %h got no pready within %0d cycles",
                                   addr, TIMEOUT));
            end
            @(negedge CLK);
            #(SAMPLE_DLY);
            cycles++;
        end
        // instruction writes wait once for the unit, all else is immediate
        check_waits(cycles, (write && addr == gemm_pkg::REG_INSTR) ? 1 : 0,
                    $sformatf("APB access to %h", addr));
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge CLK);                   // transfer closed on the rising edge
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input gemm_pkg::apb_addr_t addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input gemm_pkg::apb_addr_t addr, output logic [31:0] data,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    function automatic gemm_pkg::mreg_idx_t rand_idx();
        logic [31:0] r;
        r = $random(seed);
        return r[3:0];
    endfunction

    // field layout: opcode 6..0, rs1 10..7, rs2 14..11, rs3 18..15, rd 22..19
    function automatic gemm_pkg::instr_t make_instr(input gemm_pkg::opcode_t opc,
                                                    input gemm_pkg::mreg_idx_t rs1, rs2, rs3, rd);
        return {9'b0, rd, rs3, rs2, rs1, opc};
    endfunction

    function automatic gemm_pkg::gemm_op_t make_op(input gemm_pkg::mreg_idx_t rs1, rs2, rs3, rd,
                                                   input logic nw);
        gemm_pkg::gemm_op_t op;
        op.rs1         = rs1;
        op.rs2         = rs2;
        op.rs3         = rs3;
        op.rd          = rd;
        op.new_weights = nw;
        return op;
    endfunction

    task automatic write_instr(input gemm_pkg::instr_t word, input logic want_err,
                               input string what);
        logic err;
        apb_write(gemm_pkg::REG_INSTR, word, err);
        check_err(err, want_err, what);
    endtask

    // accepted GEMM with random rs2/rs3/rd, expected op goes to the model queue
    task automatic send_gemm(input gemm_pkg::mreg_idx_t rs1, input logic nw);
        gemm_pkg::mreg_idx_t rs2, rs3, rd;
        rs2 = rand_idx();
        rs3 = rand_idx();
        rd  = rand_idx();
        write_instr(make_instr(gemm_pkg::OPC_GEMM, rs1, rs2, rs3, rd), 1'b0, "gemm write");
        want_q.push_back(make_op(rs1, rs2, rs3, rd, nw));
    endtask

    task automatic send_store(input gemm_pkg::mreg_idx_t rd, input logic want_err,
                              input string what);
        write_instr(make_instr(gemm_pkg::OPC_STORE_M, 4'd0, 4'd0, 4'd0, rd), want_err, what);
    endtask

    task automatic read_ops();
        logic [31:0]        data;
        logic               err;
        gemm_pkg::gemm_op_t want;
        while (want_q.size() > 0) begin
            want = want_q.pop_front();
            apb_read(gemm_pkg::REG_OP, data, err);
            check_err(err, 1'b0, "op read");
            check_word(data & 32'hFFFE_0000, 32'h0, "op upper bits");
            check_op(gemm_pkg::gemm_op_t'(data[16:0]), want, "queued op");
        end
    endtask

    task automatic check_status(input int n, input string what);
        logic [31:0] data;
        logic        err;
        apb_read(gemm_pkg::REG_STATUS, data, err);
        check_err(err, 1'b0, what);
        check_word(data, {22'b0, n == 0, n == DEPTH, 8'(n)}, what);
    endtask

    task automatic flush_queue();
        logic err;
        apb_write(gemm_pkg::REG_CTRL, 32'h2, err);
        check_err(err, 1'b0, "flush write");
        want_q.delete();
    endtask

    task automatic test_decode();
        gemm_pkg::mreg_idx_t w;
        w = rand_idx();
        send_gemm(w, 1'b1);               // first since reset
        check_status(1, "status after one gemm");
        read_ops();
        check_status(0, "status after pop");
    endtask

    task automatic test_weights_reuse();
        gemm_pkg::mreg_idx_t w;
        w = rand_idx();
        flush_queue();
        send_gemm(w, 1'b1);
        send_gemm(w, 1'b0);
        send_gemm(w + 4'd1, 1'b1);
        check_status(3, "status after three gemms");
        read_ops();
    endtask

    task automatic test_store_weights();
        gemm_pkg::mreg_idx_t w;
        w = rand_idx();
        flush_queue();
        send_gemm(w, 1'b1);
        send_store(w + 4'd5, 1'b0, "store to other reg");
        send_gemm(w, 1'b0);
        send_store(w, 1'b0, "store to weights reg");
        check_status(2, "stores are not queued");
        send_gemm(w, 1'b1);               // weights overwritten by the store
        read_ops();
    endtask

    task automatic test_rejects();
        gemm_pkg::mreg_idx_t w;
        logic [31:0]         data;
        logic                err;
        w = rand_idx();
        flush_queue();
        write_instr(make_instr(7'h33, w, 4'd1, 4'd2, 4'd3), 1'b1, "unknown opcode");
        check_status(0, "count after unknown opcode");
        apb_write(gemm_pkg::REG_CTRL, 32'h1, err);
        check_err(err, 1'b0, "freeze write");
        apb_read(gemm_pkg::REG_CTRL, data, err);
        check_err(err, 1'b0, "freeze read");
        check_word(data, 32'h1, "freeze readback");
        write_instr(make_instr(gemm_pkg::OPC_GEMM, w, 4'd1, 4'd2, 4'd3), 1'b1, "gemm frozen");
        send_store(w, 1'b1, "store frozen");
        check_status(0, "count while frozen");
        apb_write(gemm_pkg::REG_CTRL, 32'h0, err);
        check_err(err, 1'b0, "unfreeze write");
        // rejects left tracking alone, so the first one still loads
        for (int i = 0; i < DEPTH; i++) begin
            send_gemm(w, i == 0);
        end
        check_status(DEPTH, "queue full");
        write_instr(make_instr(gemm_pkg::OPC_GEMM, w + 4'd1, 4'd0, 4'd0, 4'd0), 1'b1,
                    "gemm into full queue");
        check_status(DEPTH, "count after full reject");
        read_ops();
        apb_read(gemm_pkg::REG_OP, data, err);
        check_err(err, 1'b1, "op read while empty");
        check_word(data, 32'h0, "op data while empty");
        apb_read(8'h10, data, err);
        check_err(err, 1'b1, "unknown offset read");
        check_status(0, "count after empty read");
    endtask

    task automatic test_flush();
        gemm_pkg::mreg_idx_t w;
        w = rand_idx();
        flush_queue();
        send_gemm(w, 1'b1);
        send_gemm(w, 1'b0);
        check_status(2, "status before flush");
        flush_queue();
        check_status(0, "status after flush");
        send_gemm(w, 1'b1);               // tracking cleared as well
        read_ops();
    endtask

    initial begin
        apb_req = '0;
        nRST    = 1'b0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        test_decode();
        test_weights_reuse();
        test_store_weights();
        test_rejects();
        test_flush();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* gemm_issue_top.f */
src/gemm_pkg.sv
src/gemm_apb_regs.sv
src/fu_gemm.sv
src/gemm_op_fifo.sv
src/gemm_issue_top.sv
verif/gemm_issue_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the GEMM issue front end testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=gemm_issue_sim

verilator --binary --timing --assert \
    -f gemm_issue_top.f \
    --top-module gemm_issue_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0
